//--- bench/istream_checker.sv
`include "istream_cfg.svh"

module istream_checker
    import istream_pkg::*;
(
    input  logic                                CLK,
    input  logic                                nRST,
    input  logic                                enq_valid,
    input  chunk_vec_t                          enq_chunk_valid,
    input  instr_2b_t [`ISTREAM_CHUNKS-1:0]     enq_instr,
    input  logic [31:0]                         enq_after_pc,
    input  logic                                enq_stall,
    input  logic                                deq_valid,
    input  way_vec_t                            deq_way_valid,
    input  way_vec_t                            deq_way_uncompressed,
    input  instr_2b_t [`ISTREAM_WAYS-1:0][1:0]  deq_way_instr,
    input  logic [`ISTREAM_WAYS-1:0][31:0]      deq_way_pc,
    input  logic                                deq_stall,
    input  logic                                restart,
    input  logic [31:0]                         restart_pc,
    // table expectations where 2 skips the check
    input  logic [1:0]                          exp_stall,
    input  logic [1:0]                          exp_deq,
    input  int                                  test_id,
    output int                                  error_count,
    output int                                  check_count
);

    localparam logic [31:0] INIT_PC = `ISTREAM_INIT_PC;

    // pending chunks in program order as {pc, chunk}
    logic [47:0]    chunk_q [$];
    logic [27:0]    next_base;
    int             last_id;
    int             test_errors;
    int             test_checks;

    task automatic note_error();
        error_count++;
        test_errors++;
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %0h expected %0h", name, got, exp);
            note_error();
        end
    endtask

    task automatic report_failure(input string msg);
        $display("Error: %s", msg);
        note_error();
    endtask

    // ----------------------------------------------------------------------
    // pop one expected instruction for a delivered way
    // ----------------------------------------------------------------------

    task automatic pop_and_compare(input int k);
        logic [47:0] lo;
        logic [47:0] hi;
        logic        unc;

        if (chunk_q.size() == 0) begin
            report_failure($sformatf("way %0d delivered an instruction nobody fetched", k));
            return;
        end
        lo  = chunk_q.pop_front();
        unc = (lo[1:0] == 2'b11);
        hi  = '0;
        if (unc) begin
            if (chunk_q.size() == 0) begin
                report_failure($sformatf(
                    "way %0d delivered an instruction missing its upper half", k));
                return;
            end
            hi = chunk_q.pop_front();
        end
        check_count++;
        test_checks++;
        compare_value($sformatf("deq_way_pc[%0d]", k), deq_way_pc[k], lo[47:16]);
        compare_value($sformatf("deq_way_instr[%0d][0]", k),
                      32'(deq_way_instr[k][0]), 32'(lo[15:0]));
        compare_value($sformatf("deq_way_uncompressed[%0d]", k),
                      32'(deq_way_uncompressed[k]), 32'(unc));
        if (unc) begin
            compare_value($sformatf("deq_way_instr[%0d][1]", k),
                          32'(deq_way_instr[k][1]), 32'(hi[15:0]));
        end
    endtask

    // ----------------------------------------------------------------------
    // per-edge model update and compare
    // ----------------------------------------------------------------------

    always @(posedge CLK) begin
        if (!nRST) begin
            chunk_q.delete();
            next_base   = INIT_PC[31:4];
            last_id     = 0;
            error_count = 0;
            check_count = 0;
            test_errors = 0;
            test_checks = 0;
        end else begin
            if (test_id != last_id) begin
                if (last_id != 0) begin
                    $display("test %0d finished: %0d instructions checked, %0d errors",
                             last_id, test_checks, test_errors);
                end
                test_errors = 0;
                test_checks = 0;
                last_id     = test_id;
                if (test_id == 0 && chunk_q.size() != 0) begin
                    report_failure($sformatf("%0d fetched chunks were never delivered",
                                             chunk_q.size()));
                end
            end

            if (exp_stall != 2'd2) compare_value("enq_stall", 32'(enq_stall), 32'(exp_stall));
            if (exp_deq != 2'd2) compare_value("deq_valid", 32'(deq_valid), 32'(exp_deq));

            // offered ways form one group from way 0
            if ((deq_way_valid & (deq_way_valid + 1'b1)) != '0) begin
                report_failure($sformatf("valid ways %b leave a gap after way 0",
                                         deq_way_valid));
            end

            if (!deq_stall) begin
                for (int k = 0; k < `ISTREAM_WAYS; k++) begin
                    if (deq_way_valid[k]) pop_and_compare(k);
                end
            end

            if (restart) begin
                chunk_q.delete();
                next_base = restart_pc[31:4];
            end else if (enq_valid && !enq_stall) begin
                for (int j = 0; j < `ISTREAM_CHUNKS; j++) begin
                    if (enq_chunk_valid[j]) begin
                        chunk_q.push_back({next_base, 3'(j), 1'b0, enq_instr[j]});
                    end
                end
                // next block starts where this one said
                next_base = enq_after_pc[31:4];
            end
        end
    end

endmodule

//--- bench/istream_tb.sv
`include "istream_cfg.svh"

module istream_tb
    import istream_pkg::*;
();

    localparam int DRAIN_CYCLES = 200;

    typedef struct packed {
        int             test;
        int             reps;
        logic           enq;
        chunk_vec_t     mask;
        logic [127:0]   chunks;
        logic [31:0]    after_pc;
        logic [1:0]     stall;      // 2 draws a fresh random value each cycle
        logic           rst;
        logic [31:0]    rst_pc;
        logic [1:0]     exp_stall;  // 2 skips the check
        logic [1:0]     exp_deq;
    } step_t;

    logic                                   CLK;
    logic                                   nRST;
    logic                                   enq_valid;
    chunk_vec_t                             enq_chunk_valid;
    instr_2b_t [`ISTREAM_CHUNKS-1:0]        enq_instr;
    logic [31:0]                            enq_after_pc;
    logic                                   enq_stall;
    logic                                   deq_valid;
    way_vec_t                               deq_way_valid;
    way_vec_t                               deq_way_uncompressed;
    instr_2b_t [`ISTREAM_WAYS-1:0][1:0]     deq_way_instr;
    logic [`ISTREAM_WAYS-1:0][31:0]         deq_way_pc;
    logic                                   deq_stall;
    logic                                   restart;
    logic [31:0]                            restart_pc;

    int             test_id;
    logic [1:0]     exp_stall;
    logic [1:0]     exp_deq;
    int             error_count;
    int             check_count;
    int             seed;
    logic           table_ready;
    step_t          steps [$];

    istream_top u_dut (.*);

    istream_checker u_chk (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // ----------------------------------------------------------------------
    // stimulus table
    // ----------------------------------------------------------------------

    // low nibble 3 marks an uncompressed start
    function automatic logic [127:0] make_chunks(input logic [7:0] tag,
                                                 input logic [7:0] unc_mask);
        logic [127:0] v;

        for (int j = 0; j < 8; j++) begin
            v[16*j +: 16] = {tag, 4'(j), unc_mask[j] ? 4'h3 : 4'h0};
        end
        return v;
    endfunction

    task automatic enqueue_step(input int test, input chunk_vec_t mask,
                                input logic [127:0] chunks, input logic [31:0] after_pc,
                                input logic [1:0] stall);
        steps.push_back(step_t'{test, 1, 1'b1, mask, chunks, after_pc, stall,
                                1'b0, 32'h0, 2'd2, 2'd2});
    endtask

    task automatic idle_steps(input int test, input int reps, input logic [1:0] stall,
                              input logic [1:0] want_stall, input logic [1:0] want_deq);
        steps.push_back(step_t'{test, reps, 1'b0, 8'h00, 128'h0, 32'h0, stall,
                                1'b0, 32'h0, want_stall, want_deq});
    endtask

    // carries an enqueue that must be dropped
    task automatic restart_step(input int test, input logic [31:0] pc);
        steps.push_back(step_t'{test, 1, 1'b1, 8'hFF, make_chunks(8'h6F, 8'h00), 32'h0,
                                2'd1, 1'b1, pc, 2'd2, 2'd2});
    endtask

    task automatic build_table();
        idle_steps(1, 1, 2'd0, 2'd0, 2'd0);
        // sequential compressed blocks
        enqueue_step(2, 8'hFF, make_chunks(8'h11, 8'h00), 32'h8000_0010, 2'd0);
        enqueue_step(2, 8'hFF, make_chunks(8'h12, 8'h00), 32'h8000_0020, 2'd0);
        enqueue_step(2, 8'hF0, make_chunks(8'h13, 8'h00), 32'h8000_0030, 2'd0);
        idle_steps(2, 8, 2'd0, 2'd2, 2'd2);
        idle_steps(2, 1, 2'd0, 2'd0, 2'd0);
        // chunk 7 waits for the next set
        enqueue_step(3, 8'hFF, make_chunks(8'h21, 8'h92), 32'h8000_0040, 2'd0);
        idle_steps(3, 3, 2'd0, 2'd0, 2'd2);
        enqueue_step(3, 8'hFF, make_chunks(8'h22, 8'h04), 32'h8000_0100, 2'd0);
        idle_steps(3, 8, 2'd0, 2'd2, 2'd2);
        idle_steps(3, 1, 2'd0, 2'd0, 2'd0);
        for (int i = 0; i < `ISTREAM_SETS; i++) begin
            enqueue_step(4, 8'hFF, make_chunks(8'h40 + 8'(i), 8'h00),
                         32'h8000_0110 + 32'(16 * i), 2'd1);
        end
        idle_steps(4, 2, 2'd1, 2'd1, 2'd1);
        idle_steps(4, 30, 2'd0, 2'd2, 2'd2);
        idle_steps(4, 1, 2'd0, 2'd0, 2'd0);
        for (int i = 0; i < 6; i++) begin
            enqueue_step(5, 8'hFF, make_chunks(8'h50 + 8'(i), (i < 5) ? 8'h92 : 8'h12),
                         32'h8000_0190 + 32'(16 * i), 2'd2);
            idle_steps(5, 2, 2'd2, 2'd2, 2'd2);
        end
        idle_steps(5, 30, 2'd0, 2'd2, 2'd2);
        idle_steps(5, 1, 2'd0, 2'd0, 2'd0);
        enqueue_step(6, 8'hFF, make_chunks(8'h61, 8'h00), 32'h8000_0200, 2'd1);
        enqueue_step(6, 8'hFF, make_chunks(8'h62, 8'h00), 32'h8000_0210, 2'd1);
        restart_step(6, 32'h4000_0200);
        idle_steps(6, 1, 2'd0, 2'd0, 2'd0);
        enqueue_step(6, 8'h3F, make_chunks(8'h63, 8'h10), 32'h4000_0210, 2'd0);
        idle_steps(6, 8, 2'd0, 2'd2, 2'd2);
        idle_steps(6, 1, 2'd0, 2'd0, 2'd0);
    endtask

    task automatic drive_step(input step_t s);
        enq_valid       <= s.enq;
        enq_chunk_valid <= s.mask;
        enq_instr       <= s.chunks;
        enq_after_pc    <= s.after_pc;
        deq_stall       <= (s.stall == 2'd2) ? 1'($random(seed)) : s.stall[0];
        restart         <= s.rst;
        restart_pc      <= s.rst_pc;
        exp_stall       <= s.exp_stall;
        exp_deq         <= s.exp_deq;
        test_id         <= s.test;
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------

    initial begin : run
        step_t s;

        seed            = 68;
        table_ready     = 1'b0;
        nRST            = 1'b0;
        enq_valid       = 1'b0;
        enq_chunk_valid = '0;
        enq_instr       = '0;
        enq_after_pc    = '0;
        deq_stall       = 1'b0;
        restart         = 1'b0;
        restart_pc      = '0;
        exp_stall       = 2'd2;
        exp_deq         = 2'd2;
        test_id         = 0;
        build_table();
        table_ready = 1'b1;

        repeat (16) @(posedge CLK);
        nRST <= 1'b1;

        for (int i = 0; i < steps.size(); i++) begin
            s = steps[i];
            for (int r = 0; r < s.reps; r++) begin
                drive_step(s);
                @(posedge CLK);
                // hold the set until the store takes it
                while (s.enq && !s.rst && enq_stall) begin
                    drive_step(s);
                    @(posedge CLK);
                end
            end
        end

        drive_step(step_t'{0, 1, 1'b0, 8'h00, 128'h0, 32'h0, 2'd0, 1'b0, 32'h0, 2'd2, 2'd2});
        repeat (2) @(posedge CLK);
        @(negedge CLK);

        $display("closing: %0d instructions checked, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        wait (table_ready === 1'b1);
        repeat (steps.size() * 20 + DRAIN_CYCLES) @(posedge CLK);
        $display("watchdog expired: the stimulus table did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- common/istream_cfg.svh
`ifndef ISTREAM_CFG_SVH
`define ISTREAM_CFG_SVH

// ----------------------------------------------------------------------
// instruction stream buffer sizing
// ----------------------------------------------------------------------

// fetch sets held in the ring, power of two
`define ISTREAM_SETS 8

// 2-byte chunks per fetch set
`define ISTREAM_CHUNKS 8

// instructions offered per cycle
`define ISTREAM_WAYS 4

// fetch address out of reset
`define ISTREAM_INIT_PC 32'h8000_0000

`endif

//--- common/istream_pkg.sv
`include "istream_cfg.svh"

package istream_pkg;

    // one 2-byte instruction chunk
    typedef logic [15:0] instr_2b_t;

    // per-chunk flags of a single fetch set
    typedef logic [`ISTREAM_CHUNKS-1:0] chunk_vec_t;

    // per-chunk flags across the two oldest sets
    typedef logic [2*`ISTREAM_CHUNKS-1:0] window_vec_t;

    // chunk position within the window, msb selects the set
    typedef logic [$clog2(2*`ISTREAM_CHUNKS)-1:0] window_idx_t;

    // per-way flags on the dequeue side
    typedef logic [`ISTREAM_WAYS-1:0] way_vec_t;

    // 16-byte-aligned fetch block base
    typedef logic [27:0] pc28_t;

    // ring slot plus wrap bit
    typedef logic [$clog2(`ISTREAM_SETS):0] set_ptr_t;

endpackage

//--- hw/lsb_picker.sv
module lsb_picker #(
    parameter int WIDTH = 16
) (
    input  logic [WIDTH-1:0]                                req_vec,
    output logic [WIDTH-1:0]                                ack_one_hot,
    output logic [WIDTH-1:0]                                cold_ack_mask,
    output logic [((WIDTH > 1) ? $clog2(WIDTH) : 1)-1:0]    ack_index
);

    localparam int IDX_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    // ----------------------------------------------------------------------
    // lowest requester wins
    // ----------------------------------------------------------------------

    always_comb begin : pick
        logic found;

        found         = 1'b0;
        ack_one_hot   = '0;
        cold_ack_mask = '0;
        ack_index     = '0;

        for (int i = 0; i < WIDTH; i++) begin
            // everything past the winner is cold
            cold_ack_mask[i] = found;

            if (req_vec[i] && !found) begin
                ack_one_hot[i] = 1'b1;
                ack_index      = IDX_W'(i);
                found          = 1'b1;
            end
        end
    end

endmodule

//--- istream.f
+incdir+common
common/istream_pkg.sv
hw/lsb_picker.sv
istream/stream_set_store.sv
istream/way_extract.sv
istream/istream_top.sv
bench/istream_checker.sv
bench/istream_tb.sv

//--- istream/istream_top.sv
`include "istream_cfg.svh"

module istream_top
    import istream_pkg::*;
(
    input  logic                                    CLK,
    input  logic                                    nRST,

    // fetch side
    input  logic                                    enq_valid,
    input  chunk_vec_t                              enq_chunk_valid,
    input  instr_2b_t [`ISTREAM_CHUNKS-1:0]         enq_instr,
    input  logic [31:0]                             enq_after_pc,
    output logic                                    enq_stall,

    // decode side
    output logic                                    deq_valid,
    output way_vec_t                                deq_way_valid,
    output way_vec_t                                deq_way_uncompressed,
    output instr_2b_t [`ISTREAM_WAYS-1:0][1:0]      deq_way_instr,
    output logic [`ISTREAM_WAYS-1:0][31:0]          deq_way_pc,
    input  logic                                    deq_stall,

    // flush
    input  logic                                    restart,
    input  logic [31:0]                             restart_pc
);

    // ----------------------------------------------------------------------
    // two-set window between store and extractor
    // ----------------------------------------------------------------------

    window_vec_t                            win_chunk_valid;
    window_vec_t                            win_uncompressed;
    instr_2b_t [2*`ISTREAM_CHUNKS-1:0]      win_instr;
    pc28_t                                  win_base0;
    pc28_t                                  win_base1;
    window_vec_t                            win_ack;

    stream_set_store #(
        .SETS(`ISTREAM_SETS)
    ) u_store (
        .CLK              (CLK),
        .nRST             (nRST),
        .restart          (restart),
        .restart_pc       (restart_pc),
        .enq_valid        (enq_valid),
        .enq_chunk_valid  (enq_chunk_valid),
        .enq_instr        (enq_instr),
        .enq_after_pc     (enq_after_pc),
        .enq_stall        (enq_stall),
        .deq_stall        (deq_stall),
        .win_ack          (win_ack),
        .win_chunk_valid  (win_chunk_valid),
        .win_uncompressed (win_uncompressed),
        .win_instr        (win_instr),
        .win_base0        (win_base0),
        .win_base1        (win_base1)
    );

    way_extract u_extract (
        .win_chunk_valid      (win_chunk_valid),
        .win_uncompressed     (win_uncompressed),
        .win_instr            (win_instr),
        .win_base0            (win_base0),
        .win_base1            (win_base1),
        .win_ack              (win_ack),
        .deq_valid            (deq_valid),
        .deq_way_valid        (deq_way_valid),
        .deq_way_uncompressed (deq_way_uncompressed),
        .deq_way_instr        (deq_way_instr),
        .deq_way_pc           (deq_way_pc)
    );

endmodule

//--- istream/stream_set_store.sv
`include "istream_cfg.svh"

module stream_set_store
    import istream_pkg::*;
#(
    parameter int SETS = `ISTREAM_SETS
) (
    input  logic                                    CLK,
    input  logic                                    nRST,

    input  logic                                    restart,
    input  logic [31:0]                             restart_pc,

    input  logic                                    enq_valid,
    input  chunk_vec_t                              enq_chunk_valid,
    input  instr_2b_t [`ISTREAM_CHUNKS-1:0]         enq_instr,
    input  logic [31:0]                             enq_after_pc,
    output logic                                    enq_stall,

    input  logic                                    deq_stall,

    input  window_vec_t                             win_ack,
    output window_vec_t                             win_chunk_valid,
    output window_vec_t                             win_uncompressed,
    output instr_2b_t [2*`ISTREAM_CHUNKS-1:0]       win_instr,
    output pc28_t                                   win_base0,
    output pc28_t                                   win_base1
);

    localparam int CH    = `ISTREAM_CHUNKS;
    localparam int IDX_W = $clog2(SETS);
    localparam logic [31:0] INIT_PC = `ISTREAM_INIT_PC;

    // ----------------------------------------------------------------------
    // storage
    // ----------------------------------------------------------------------

    instr_2b_t [CH-1:0] set_instr [SETS];
    pc28_t              set_after [SETS];

    // still-pending chunks and uncompressed starts per set
    chunk_vec_t         set_pend  [SETS];
    chunk_vec_t         set_unc   [SETS];

    logic [IDX_W:0]     enq_ptr;
    logic [IDX_W:0]     head_ptr;
    logic [IDX_W:0]     head_ptr_p1;
    logic [IDX_W:0]     occupancy;
    logic [IDX_W-1:0]   enq_idx;
    logic [IDX_W-1:0]   head_idx;
    logic [IDX_W-1:0]   next_idx;
    pc28_t              head_base;

    chunk_vec_t         enq_unc;
    logic               enq_fire;
    logic               occ0;
    logic               occ1;
    logic               done0;
    logic               done1;
    logic               retire_one;
    logic               retire_two;

    // ----------------------------------------------------------------------
    // pointers and status
    // ----------------------------------------------------------------------

    assign head_ptr_p1 = head_ptr + 1'b1;
    assign enq_idx     = enq_ptr[IDX_W-1:0];
    assign head_idx    = head_ptr[IDX_W-1:0];
    assign next_idx    = head_ptr_p1[IDX_W-1:0];
    assign occupancy   = enq_ptr - head_ptr;

    // head and second set hold data
    assign occ0 = (occupancy != '0);
    assign occ1 = (occupancy > (IDX_W + 1)'(1));

    // same slot, other lap
    assign enq_stall = (enq_idx == head_idx) && (enq_ptr[IDX_W] != head_ptr[IDX_W]);

    // an enqueue alongside a restart is dropped
    assign enq_fire = enq_valid && !enq_stall && !restart;

    // low two bits both set mark an uncompressed start
    always_comb begin
        for (int i = 0; i < CH; i++) begin
            enq_unc[i] = (enq_instr[i][1:0] == 2'b11);
        end
    end

    // ----------------------------------------------------------------------
    // window towards the extractor
    // ----------------------------------------------------------------------

    always_comb begin
        win_chunk_valid          = '0;
        win_chunk_valid[CH-1:0]  = occ0 ? set_pend[head_idx] : '0;
        win_chunk_valid[2*CH-1:CH] = occ1 ? set_pend[next_idx] : '0;

        win_uncompressed           = '0;
        win_uncompressed[CH-1:0]   = set_unc[head_idx];
        win_uncompressed[2*CH-1:CH] = set_unc[next_idx];

        for (int i = 0; i < CH; i++) begin
            win_instr[i]      = set_instr[head_idx][i];
            win_instr[CH + i] = set_instr[next_idx][i];
        end
    end

    assign win_base0 = head_base;
    assign win_base1 = set_after[head_idx];

    // ----------------------------------------------------------------------
    // retirement
    // ----------------------------------------------------------------------

    assign done0 = occ0 && ((set_pend[head_idx] & ~win_ack[CH-1:0]) == '0);
    assign done1 = occ1 && ((set_pend[next_idx] & ~win_ack[2*CH-1:CH]) == '0);

    // second set only goes along with the head
    assign retire_one = !deq_stall && done0;
    assign retire_two = retire_one && done1;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            enq_ptr   <= '0;
            head_ptr  <= '0;
            head_base <= INIT_PC[31:4];
            for (int s = 0; s < SETS; s++) begin
                set_pend[s] <= '0;
                set_unc[s]  <= '0;
            end
        end else if (restart) begin
            enq_ptr   <= '0;
            head_ptr  <= '0;
            head_base <= restart_pc[31:4];
            for (int s = 0; s < SETS; s++) begin
                set_pend[s] <= '0;
                set_unc[s]  <= '0;
            end
        end else begin
            // drop chunks the extractor consumed
            if (!deq_stall) begin
                if (occ0) begin
                    set_pend[head_idx] <= set_pend[head_idx] & ~win_ack[CH-1:0];
                end
                if (occ1) begin
                    set_pend[next_idx] <= set_pend[next_idx] & ~win_ack[2*CH-1:CH];
                end
            end

            if (retire_two) begin
                head_ptr  <= head_ptr + (IDX_W + 1)'(2);
                head_base <= set_after[next_idx];
            end else if (retire_one) begin
                head_ptr  <= head_ptr_p1;
                head_base <= set_after[head_idx];
            end

            if (enq_fire) begin
                set_pend[enq_idx] <= enq_chunk_valid;
                set_unc[enq_idx]  <= enq_unc;
                enq_ptr           <= enq_ptr + 1'b1;
            end
        end
    end

    // set payload
    always_ff @(posedge CLK) begin
        if (enq_fire) begin
            set_instr[enq_idx] <= enq_instr;
            set_after[enq_idx] <= enq_after_pc[31:4];
        end
    end

endmodule

//--- istream/way_extract.sv
`include "istream_cfg.svh"

module way_extract
    import istream_pkg::*;
(
    input  window_vec_t                                 win_chunk_valid,
    input  window_vec_t                                 win_uncompressed,
    input  instr_2b_t [2*`ISTREAM_CHUNKS-1:0]           win_instr,
    input  pc28_t                                       win_base0,
    input  pc28_t                                       win_base1,
    output window_vec_t                                 win_ack,

    output logic                                        deq_valid,
    output way_vec_t                                    deq_way_valid,
    output way_vec_t                                    deq_way_uncompressed,
    output instr_2b_t [`ISTREAM_WAYS-1:0][1:0]          deq_way_instr,
    output logic [`ISTREAM_WAYS-1:0][31:0]              deq_way_pc
);

    localparam int CH    = `ISTREAM_CHUNKS;
    localparam int W     = 2 * CH;
    localparam int WAYS  = `ISTREAM_WAYS;
    localparam int IDX_W = $clog2(W);

    window_vec_t        marker;

    window_vec_t        lower_req  [WAYS];
    window_vec_t        lower_hot  [WAYS];
    window_vec_t        lower_cold [WAYS];
    window_idx_t        lower_idx  [WAYS];

    window_vec_t        upper_req  [WAYS];
    window_vec_t        upper_hot  [WAYS];
    window_idx_t        upper_idx  [WAYS];

    logic [WAYS-1:0]    lower_present;
    logic [WAYS-1:0]    upper_present;
    logic [WAYS-1:0]    lower_unc;

    // ----------------------------------------------------------------------
    // instruction start markers
    // ----------------------------------------------------------------------

    always_comb begin
        marker[0] = win_chunk_valid[0];
        for (int i = 1; i < W; i++) begin
            // upper half of an uncompressed start is not a start
            marker[i] = win_chunk_valid[i] & ~(marker[i-1] & win_uncompressed[i-1]);
        end
        // top chunk has no room for its upper half
        marker[W-1] = marker[W-1] & ~win_uncompressed[W-1];
    end

    // ----------------------------------------------------------------------
    // per-way lower and upper picking
    // ----------------------------------------------------------------------

    for (genvar k = 0; k < WAYS; k++) begin : g_way
        if (k == 0) begin : g_first
            assign lower_req[k] = marker;
        end else begin : g_next
            // search above the previous way's start
            assign lower_req[k] = marker & lower_cold[k-1];
        end

        // upper is the next valid chunk after the lower
        assign upper_req[k] = win_chunk_valid & lower_cold[k];

        lsb_picker #(
            .WIDTH(W)
        ) u_lower (
            .req_vec       (lower_req[k]),
            .ack_one_hot   (lower_hot[k]),
            .cold_ack_mask (lower_cold[k]),
            .ack_index     (lower_idx[k])
        );

        lsb_picker #(
            .WIDTH(W)
        ) u_upper (
            .req_vec       (upper_req[k]),
            .ack_one_hot   (upper_hot[k]),
            .cold_ack_mask (),
            .ack_index     (upper_idx[k])
        );
    end

    // ----------------------------------------------------------------------
    // way validity and acknowledge
    // ----------------------------------------------------------------------

    always_comb begin : way_valid
        logic chain;

        chain   = 1'b1;
        win_ack = '0;

        for (int k = 0; k < WAYS; k++) begin
            lower_present[k] = |lower_hot[k];
            upper_present[k] = |upper_hot[k];
            lower_unc[k]     = |(win_uncompressed & lower_hot[k]);

            // an uncompressed start needs its upper half as well
            deq_way_valid[k] = chain && lower_present[k]
                               && (!lower_unc[k] || upper_present[k]);
            chain            = deq_way_valid[k];

            if (deq_way_valid[k]) begin
                win_ack = win_ack | lower_hot[k];
                if (lower_unc[k]) begin
                    win_ack = win_ack | upper_hot[k];
                end
            end
        end
    end

    assign deq_valid            = deq_way_valid[0];
    assign deq_way_uncompressed = lower_unc;

    // ----------------------------------------------------------------------
    // payload and PC
    // ----------------------------------------------------------------------

    always_comb begin
        for (int k = 0; k < WAYS; k++) begin
            deq_way_instr[k][0] = win_instr[lower_idx[k]];
            deq_way_instr[k][1] = win_instr[upper_idx[k]];

            // window msb set means the lower sits in the second set
            if (lower_idx[k][IDX_W-1]) begin
                deq_way_pc[k] = {win_base1, lower_idx[k][IDX_W-2:0], 1'b0};
            end else begin
                deq_way_pc[k] = {win_base0, lower_idx[k][IDX_W-2:0], 1'b0};
            end
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the istream testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -f "$LOG"

verilator --binary -Wno-fatal --top-module istream_tb -Mdir "$OBJ" -o istream_sim \
    -f istream.f > "$LOG" 2>&1 \
    && "./$OBJ/istream_sim" >> "$LOG" 2>&1 \
    || { echo "compile or run failed, see $LOG"; exit 1; }

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi

echo "simulation passed"
exit 0
